// ==== verilog/rv_ctrl_pkg.sv ====
// Shared RV32I control encodings and types, imported by the decode stage and its testbench
`default_nettype none

package rv_ctrl_pkg;

    typedef logic [31:0] inst_t;      // One instruction word
    typedef logic [16:0] ctl_key_t;   // {opcode, funct3, funct7}
    typedef logic [9:0]  mem_key_t;   // {opcode, funct3}

    // Major opcodes that the control table decodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;  // Register-register ALU
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // Register-immediate ALU
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    localparam inst_t      EBREAK_INST = 32'h0010_0073;  // Whole word, no operand fields
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;     // SUB, SRA and SRAI marker

    // Branch condition codes in funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam int NR_CTL_KEYS = 36;  // Rows in the control table
    localparam int NR_MEM_KEYS = 8;   // Rows in the access-size table

    typedef enum logic [4:0] {
        ALU_ADD  = 5'd0,
        ALU_SUB  = 5'd1,
        ALU_SLT  = 5'd2,
        ALU_SLTU = 5'd3,
        ALU_XOR  = 5'd4,
        ALU_OR   = 5'd5,
        ALU_AND  = 5'd6,
        ALU_SLL  = 5'd7,
        ALU_SRL  = 5'd8,
        ALU_SRA  = 5'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        OP1_RS1 = 2'd0,
        OP1_PC  = 2'd1    // AUIPC only
    } op1_sel_e;

    typedef enum logic [1:0] {
        OP2_NONE = 2'd0,
        OP2_IMM  = 2'd1,  // I-type immediate
        OP2_SIMM = 2'd2,  // S-type immediate
        OP2_RS2  = 2'd3
    } op2_sel_e;

    typedef enum logic [2:0] {
        PC_PLUS4  = 3'd0,
        PC_JALR   = 3'd1,
        PC_BRANCH = 3'd2,  // Only set by the branch resolver
        PC_JAL    = 3'd3
    } pc_sel_e;

    typedef enum logic [1:0] {
        WB_NONE = 2'd0,
        WB_PC4  = 2'd1,   // Link address
        WB_ALU  = 2'd2,
        WB_MEM  = 2'd3    // Load data
    } wb_sel_e;

    // Matches funct3 of loads and stores, zero otherwise
    typedef enum logic [2:0] {
        MEM_B  = 3'd0,
        MEM_H  = 3'd1,
        MEM_W  = 3'd2,
        MEM_BU = 3'd4,
        MEM_HU = 3'd5
    } mem_size_e;

    typedef struct packed {
        alu_op_e  alu_op;   // [16:12]
        op1_sel_e op1_sel;  // [11:10]
        op2_sel_e op2_sel;  // [9:8]
        pc_sel_e  pc_sel;   // [7:5]
        logic     rf_we;    // [4]
        logic     mem_en;   // [3]
        logic     mem_wen;  // [2]
        wb_sel_e  wb_sel;   // [1:0]
    } ctl_word_t;

endpackage

`default_nettype wire

// ==== verilog/key_mux.sv ====
// Generic key-matching lookup table, instantiated by the decoder once per payload type
`default_nettype none

module key_mux #(
    parameter int  NR_KEY = 2,       // Number of table rows
    parameter type key_t  = logic,   // Row key type
    parameter type data_t = logic    // Row payload type
) (
    input  key_t  key,               // Lookup key
    input  key_t  keys  [NR_KEY],    // Key column of the table
    input  data_t datas [NR_KEY],    // Payload column of the table
    output data_t data               // OR of matching payloads
);

    localparam int DATA_W = $bits(data_t);

    logic [DATA_W-1:0] hit_or;  // Accumulated payload bits

    // All rows compared in parallel, no priority
    always_comb begin
        hit_or = '0;
        for (int i = 0; i < NR_KEY; i++) begin
            if (key == keys[i]) begin
                hit_or = hit_or | DATA_W'(datas[i]);  // Rows are unique so at most one hit
            end
        end
    end

    assign data = data_t'(hit_or);  // Zero when nothing matches

endmodule

`default_nettype wire

// ==== verilog/inst_decoder.sv ====
// Combinational RV32I decode of control word, access size and EBREAK, used by the control stage
`default_nettype none

module inst_decoder (
    input  rv_ctrl_pkg::inst_t     inst,       // Instruction word
    output rv_ctrl_pkg::ctl_word_t ctl_word,   // Table control word
    output rv_ctrl_pkg::mem_size_e mem_size,   // Load and store size
    output logic                   is_ebreak   // Exact EBREAK match
);

    import rv_ctrl_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    ctl_key_t   ctl_key;  // Normalised control key
    mem_key_t   mem_key;

    assign opcode  = inst[6:0];
    assign funct3  = inst[14:12];
    assign funct7  = inst[31:25];
    assign mem_key = {opcode, funct3};

    // Drop the fields a format does not decode on
    always_comb begin
        case (opcode)
            OPC_OP: begin
                ctl_key = {opcode, funct3, funct7};  // Full key
            end
            OPC_OP_IMM: begin
                if (funct3 == 3'b101) begin
                    ctl_key = {opcode, funct3, funct7};  // SRLI and SRAI differ in funct7
                end else begin
                    ctl_key = {opcode, funct3, 7'h00};   // funct7 is immediate here
                end
            end
            OPC_LOAD, OPC_STORE, OPC_BRANCH, OPC_JALR: begin
                ctl_key = {opcode, funct3, 7'h00};  // JALR misses unless funct3 is 000
            end
            OPC_JAL, OPC_AUIPC: begin
                ctl_key = {opcode, 10'h000};  // No funct fields
            end
            default: begin
                ctl_key = {opcode, funct3, funct7};  // Unknown opcode never matches
            end
        endcase
    end

    localparam ctl_key_t CTL_KEYS [NR_CTL_KEYS] = '{
        {OPC_OP,     3'b000, 7'h00},       // ADD
        {OPC_OP,     3'b000, FUNCT7_ALT},  // SUB
        {OPC_OP,     3'b001, 7'h00},       // SLL
        {OPC_OP,     3'b010, 7'h00},       // SLT
        {OPC_OP,     3'b011, 7'h00},       // SLTU
        {OPC_OP,     3'b100, 7'h00},       // XOR
        {OPC_OP,     3'b101, 7'h00},       // SRL
        {OPC_OP,     3'b101, FUNCT7_ALT},  // SRA
        {OPC_OP,     3'b110, 7'h00},       // OR
        {OPC_OP,     3'b111, 7'h00},       // AND
        {OPC_OP_IMM, 3'b000, 7'h00},       // ADDI
        {OPC_OP_IMM, 3'b010, 7'h00},       // SLTI
        {OPC_OP_IMM, 3'b011, 7'h00},       // SLTIU
        {OPC_OP_IMM, 3'b100, 7'h00},       // XORI
        {OPC_OP_IMM, 3'b110, 7'h00},       // ORI
        {OPC_OP_IMM, 3'b111, 7'h00},       // ANDI
        {OPC_OP_IMM, 3'b001, 7'h00},       // SLLI
        {OPC_OP_IMM, 3'b101, 7'h00},       // SRLI
        {OPC_OP_IMM, 3'b101, FUNCT7_ALT},  // SRAI
        {OPC_LOAD,   3'b000, 7'h00},       // LB
        {OPC_LOAD,   3'b001, 7'h00},       // LH
        {OPC_LOAD,   3'b010, 7'h00},       // LW
        {OPC_LOAD,   3'b100, 7'h00},       // LBU
        {OPC_LOAD,   3'b101, 7'h00},       // LHU
        {OPC_STORE,  3'b000, 7'h00},       // SB
        {OPC_STORE,  3'b001, 7'h00},       // SH
        {OPC_STORE,  3'b010, 7'h00},       // SW
        {OPC_BRANCH, F3_BEQ,  7'h00},      // BEQ
        {OPC_BRANCH, F3_BNE,  7'h00},      // BNE
        {OPC_BRANCH, F3_BLT,  7'h00},      // BLT
        {OPC_BRANCH, F3_BGE,  7'h00},      // BGE
        {OPC_BRANCH, F3_BLTU, 7'h00},      // BLTU
        {OPC_BRANCH, F3_BGEU, 7'h00},      // BGEU
        {OPC_JAL,    3'b000, 7'h00},       // JAL
        {OPC_JALR,   3'b000, 7'h00},       // JALR
        {OPC_AUIPC,  3'b000, 7'h00}        // AUIPC
    };

    // alu_op, op1, op2, pc, rf_we, mem_en, mem_wen, wb
    localparam ctl_word_t CTL_WORDS [NR_CTL_KEYS] = '{
        '{ALU_ADD,  OP1_RS1, OP2_RS2,  PC_PLUS4, 1'b1, 1'b0, 1'b0, WB_ALU},   // ADD
        '{ALU_SUB,  OP1_RS1, OP2_RS2,  PC_PLUS4, 1'b1, 1'b0, 1'b0, WB_ALU},   // SUB
        '{ALU_SLL,  OP1_RS1, OP2_RS2,  PC_PLUS4, 1'b1, 1'b0, 1'b0, WB_ALU},   // SLL
        '{ALU_SLT,  OP1_RS1, OP2_RS2,  PC_PLUS4, 1'b1, 1'b0, 1'b0, WB_ALU},   // SLT
        '{ALU_SLTU, OP1_RS1, OP2_RS2,  PC_PLUS4, 1'b1, 1'b0, 1'b0, WB_ALU},   // SLTU
        '{ALU_XOR,  OP1_RS1, OP2_RS2,  PC_PLUS4, 1'b1, 1'b0, 1'b0, WB_ALU},   // XOR
        '{ALU_SRL,  OP1_RS1, OP2_RS2,  PC_PLUS4, 1'b1, 1'b0, 1'b0, WB_ALU},   // SRL
        '{ALU_SRA,  OP1_RS1, OP2_RS2,  PC_PLUS4, 1'b1, 1'b0, 1'b0, WB_ALU},   // SRA
        '{ALU_OR,   OP1_RS1, OP2_RS2,  PC_PLUS4, 1'b1, 1'b0, 1'b0, WB_ALU},   // OR
        '{ALU_AND,  OP1_RS1, OP2_RS2,  PC_PLUS4, 1'b1, 1'b0, 1'b0, WB_ALU},   // AND
        '{ALU_ADD,  OP1_RS1, OP2_IMM,  PC_PLUS4, 1'b1, 1'b0, 1'b0, WB_ALU},   // ADDI
        '{ALU_SLT,  OP1_RS1, OP2_IMM,  PC_PLUS4, 1'b1, 1'b0, 1'b0, WB_ALU},   // SLTI
        '{ALU_SLTU, OP1_RS1, OP2_IMM,  PC_PLUS4, 1'b1, 1'b0, 1'b0, WB_ALU},   // SLTIU
        '{ALU_XOR,  OP1_RS1, OP2_IMM,  PC_PLUS4, 1'b1, 1'b0, 1'b0, WB_ALU},   // XORI
        '{ALU_OR,   OP1_RS1, OP2_IMM,  PC_PLUS4, 1'b1, 1'b0, 1'b0, WB_ALU},   // ORI
        '{ALU_AND,  OP1_RS1, OP2_IMM,  PC_PLUS4, 1'b1, 1'b0, 1'b0, WB_ALU},   // ANDI
        '{ALU_SLL,  OP1_RS1, OP2_IMM,  PC_PLUS4, 1'b1, 1'b0, 1'b0, WB_ALU},   // SLLI
        '{ALU_SRL,  OP1_RS1, OP2_IMM,  PC_PLUS4, 1'b1, 1'b0, 1'b0, WB_ALU},   // SRLI
        '{ALU_SRA,  OP1_RS1, OP2_IMM,  PC_PLUS4, 1'b1, 1'b0, 1'b0, WB_ALU},   // SRAI
        '{ALU_ADD,  OP1_RS1, OP2_IMM,  PC_PLUS4, 1'b1, 1'b1, 1'b0, WB_MEM},   // LB
        '{ALU_ADD,  OP1_RS1, OP2_IMM,  PC_PLUS4, 1'b1, 1'b1, 1'b0, WB_MEM},   // LH
        '{ALU_ADD,  OP1_RS1, OP2_IMM,  PC_PLUS4, 1'b1, 1'b1, 1'b0, WB_MEM},   // LW
        '{ALU_ADD,  OP1_RS1, OP2_IMM,  PC_PLUS4, 1'b1, 1'b1, 1'b0, WB_MEM},   // LBU
        '{ALU_ADD,  OP1_RS1, OP2_IMM,  PC_PLUS4, 1'b1, 1'b1, 1'b0, WB_MEM},   // LHU
        '{ALU_ADD,  OP1_RS1, OP2_SIMM, PC_PLUS4, 1'b0, 1'b1, 1'b1, WB_NONE},  // SB
        '{ALU_ADD,  OP1_RS1, OP2_SIMM, PC_PLUS4, 1'b0, 1'b1, 1'b1, WB_NONE},  // SH
        '{ALU_ADD,  OP1_RS1, OP2_SIMM, PC_PLUS4, 1'b0, 1'b1, 1'b1, WB_NONE},  // SW
        '{ALU_ADD,  OP1_RS1, OP2_NONE, PC_PLUS4, 1'b0, 1'b0, 1'b0, WB_NONE},  // BEQ
        '{ALU_ADD,  OP1_RS1, OP2_NONE, PC_PLUS4, 1'b0, 1'b0, 1'b0, WB_NONE},  // BNE
        '{ALU_ADD,  OP1_RS1, OP2_NONE, PC_PLUS4, 1'b0, 1'b0, 1'b0, WB_NONE},  // BLT
        '{ALU_ADD,  OP1_RS1, OP2_NONE, PC_PLUS4, 1'b0, 1'b0, 1'b0, WB_NONE},  // BGE
        '{ALU_ADD,  OP1_RS1, OP2_NONE, PC_PLUS4, 1'b0, 1'b0, 1'b0, WB_NONE},  // BLTU
        '{ALU_ADD,  OP1_RS1, OP2_NONE, PC_PLUS4, 1'b0, 1'b0, 1'b0, WB_NONE},  // BGEU
        '{ALU_ADD,  OP1_RS1, OP2_NONE, PC_JAL,   1'b1, 1'b0, 1'b0, WB_PC4},   // JAL
        '{ALU_ADD,  OP1_RS1, OP2_IMM,  PC_JALR,  1'b1, 1'b0, 1'b0, WB_PC4},   // JALR
        '{ALU_ADD,  OP1_PC,  OP2_IMM,  PC_PLUS4, 1'b1, 1'b0, 1'b0, WB_ALU}    // AUIPC
    };

    localparam mem_key_t MEM_KEYS [NR_MEM_KEYS] = '{
        {OPC_LOAD,  3'b000},  // LB
        {OPC_LOAD,  3'b001},  // LH
        {OPC_LOAD,  3'b010},  // LW
        {OPC_LOAD,  3'b100},  // LBU
        {OPC_LOAD,  3'b101},  // LHU
        {OPC_STORE, 3'b000},  // SB
        {OPC_STORE, 3'b001},  // SH
        {OPC_STORE, 3'b010}   // SW
    };

    localparam mem_size_e MEM_SIZES [NR_MEM_KEYS] = '{
        MEM_B,   // LB
        MEM_H,   // LH
        MEM_W,   // LW
        MEM_BU,  // LBU
        MEM_HU,  // LHU
        MEM_B,   // SB
        MEM_H,   // SH
        MEM_W    // SW
    };

    key_mux #(
        .NR_KEY (NR_CTL_KEYS),
        .key_t  (ctl_key_t),
        .data_t (ctl_word_t)
    ) i_ctl_mux (
        .key   (ctl_key),
        .keys  (CTL_KEYS),
        .datas (CTL_WORDS),
        .data  (ctl_word)
    );

    key_mux #(
        .NR_KEY (NR_MEM_KEYS),
        .key_t  (mem_key_t),
        .data_t (mem_size_e)
    ) i_mem_mux (
        .key   (mem_key),
        .keys  (MEM_KEYS),
        .datas (MEM_SIZES),
        .data  (mem_size)
    );

    assign is_ebreak = (inst == EBREAK_INST);  // ECALL differs only in bit 20

endmodule

`default_nettype wire

// ==== verilog/branch_resolver.sv ====
// Next-PC selection for conditional branches, placed between the decoder and the stage register
`default_nettype none

module branch_resolver (
    input  logic [6:0]           opcode,        // Instruction opcode
    input  logic [2:0]           funct3,        // Branch condition code
    input  rv_ctrl_pkg::pc_sel_e table_pc_sel,  // Choice from the control table
    input  logic                 br_eq,         // rs1 == rs2
    input  logic                 br_lt,         // rs1 < rs2 signed
    input  logic                 br_ltu,        // rs1 < rs2 unsigned
    output rv_ctrl_pkg::pc_sel_e pc_sel         // Resolved next-PC source
);

    import rv_ctrl_pkg::*;

    logic taken;  // Branch condition holds

    always_comb begin
        case (funct3)
            F3_BEQ:  taken = br_eq;
            F3_BNE:  taken = !br_eq;
            F3_BLT:  taken = br_lt;
            F3_BGE:  taken = !br_lt;
            F3_BLTU: taken = br_ltu;
            F3_BGEU: taken = !br_ltu;
            default: taken = 1'b0;  // 010 and 011 are not branches
        endcase
    end

    // Non-branch opcodes keep the table value
    always_comb begin
        if (opcode == OPC_BRANCH) begin
            pc_sel = taken ? PC_BRANCH : PC_PLUS4;
        end else begin
            pc_sel = table_pc_sel;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ctrl_unit.sv ====
// Registered RV32I decode stage top level, samples on inst_valid and presents one word a cycle later
`default_nettype none

module ctrl_unit (
    input  logic                   clk,
    input  logic                   rst_n,       // Synchronous, active low
    input  logic                   inst_valid,  // Single-cycle sample strobe
    input  rv_ctrl_pkg::inst_t     inst,
    input  logic                   br_eq,       // Compare flags for this inst
    input  logic                   br_lt,
    input  logic                   br_ltu,
    output logic                   ctl_valid,   // Word valid this cycle
    output rv_ctrl_pkg::alu_op_e   alu_op,
    output rv_ctrl_pkg::op1_sel_e  op1_sel,
    output rv_ctrl_pkg::op2_sel_e  op2_sel,
    output rv_ctrl_pkg::pc_sel_e   pc_sel,
    output logic                   rf_we,
    output logic                   mem_en,
    output logic                   mem_wen,
    output rv_ctrl_pkg::wb_sel_e   wb_sel,
    output rv_ctrl_pkg::mem_size_e mem_size,
    output logic                   is_ebreak
);

    import rv_ctrl_pkg::*;

    ctl_word_t dec_word;       // Table word before the register
    mem_size_e dec_mem_size;
    logic      dec_is_ebreak;
    pc_sel_e   res_pc_sel;     // Next-PC after branch resolution

    inst_decoder i_decoder (
        .inst      (inst),
        .ctl_word  (dec_word),
        .mem_size  (dec_mem_size),
        .is_ebreak (dec_is_ebreak)
    );

    branch_resolver i_branch (
        .opcode       (inst[6:0]),
        .funct3       (inst[14:12]),
        .table_pc_sel (dec_word.pc_sel),
        .br_eq        (br_eq),
        .br_lt        (br_lt),
        .br_ltu       (br_ltu),
        .pc_sel       (res_pc_sel)
    );

    // Control half of the stage register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctl_valid <= 1'b0;
            pc_sel    <= PC_PLUS4;
            rf_we     <= 1'b0;
            mem_en    <= 1'b0;
            mem_wen   <= 1'b0;
            is_ebreak <= 1'b0;
        end else if (inst_valid) begin
            ctl_valid <= 1'b1;
            pc_sel    <= res_pc_sel;
            rf_we     <= dec_word.rf_we;
            mem_en    <= dec_word.mem_en;
            mem_wen   <= dec_word.mem_wen;
            is_ebreak <= dec_is_ebreak;
        end else begin
            ctl_valid <= 1'b0;  // Bubble, pc_sel holds
            rf_we     <= 1'b0;
            mem_en    <= 1'b0;
            mem_wen   <= 1'b0;
            is_ebreak <= 1'b0;
        end
    end

    // Payload half, only meaningful with ctl_valid
    always_ff @(posedge clk) begin
        if (inst_valid) begin
            alu_op   <= dec_word.alu_op;
            op1_sel  <= dec_word.op1_sel;
            op2_sel  <= dec_word.op2_sel;
            wb_sel   <= dec_word.wb_sel;
            mem_size <= dec_mem_size;
        end
    end

endmodule

`default_nettype wire

// ==== verification/ctrl_unit_props.sv ====
// Timing properties of the decode stage, bound into every ctrl_unit instance
`default_nettype none

module ctrl_unit_props (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 inst_valid,
    input logic                 ctl_valid,
    input rv_ctrl_pkg::pc_sel_e pc_sel,
    input logic                 rf_we,
    input logic                 mem_en,
    input logic                 mem_wen,
    input logic                 is_ebreak
);

    import rv_ctrl_pkg::*;

    int unsigned fail_count = 0;  // Read by the testbench at the end

    logic enables_low;
    assign enables_low = !rf_we && !mem_en && !mem_wen && !is_ebreak;

    // Reset clears valid and the enables, next PC back to PLUS4
    a_reset_state: assert property (@(posedge clk)
        !rst_n |=> !ctl_valid && enables_low && pc_sel == PC_PLUS4)
        else begin fail_count++; $error("Outputs not cleared after reset"); end

    // Exactly one cycle of latency
    a_valid_follows: assert property (@(posedge clk) disable iff (!rst_n)
        inst_valid |=> ctl_valid)
        else begin fail_count++; $error("ctl_valid missing one cycle after inst_valid"); end

    a_no_spurious_valid: assert property (@(posedge clk) disable iff (!rst_n)
        !inst_valid |=> !ctl_valid)
        else begin fail_count++; $error("ctl_valid without a strobe"); end

    a_bubble_enables: assert property (@(posedge clk) disable iff (!rst_n)
        !ctl_valid |-> enables_low)
        else begin fail_count++; $error("Enable high while ctl_valid is low"); end

    a_pc_sel_holds: assert property (@(posedge clk) disable iff (!rst_n)
        !inst_valid |=> $stable(pc_sel))
        else begin fail_count++; $error("pc_sel changed during a bubble"); end

endmodule

bind ctrl_unit ctrl_unit_props i_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .ctl_valid  (ctl_valid),
    .pc_sel     (pc_sel),
    .rf_we      (rf_we),
    .mem_en     (mem_en),
    .mem_wen    (mem_wen),
    .is_ebreak  (is_ebreak)
);

`default_nettype wire

// ==== verification/ctrl_unit_tb.sv ====
// Testbench for the registered decode stage, drives strobes and checks each word against a model
`default_nettype none

module ctrl_unit_tb;

    import rv_ctrl_pkg::*;

    localparam int CLK_HALF   = 4;
    localparam int CLK_PERIOD = 2 * CLK_HALF;
    localparam int RST_CYCLES = 3;
    localparam int NR_INST    = 36 + 48 + 13 + 24;  // Table, branch, unmatched, strobe tests
    localparam int NR_IDLE    = 40;                 // Gaps, test ends and drain
    localparam int WATCHDOG   = (NR_INST + NR_IDLE + RST_CYCLES + 20) * CLK_PERIOD;

    typedef struct packed {
        ctl_word_t  word;
        logic [2:0] size;
        logic       brk;
    } exp_t;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      inst_valid;
    inst_t     inst;
    logic      br_eq;
    logic      br_lt;
    logic      br_ltu;
    logic      ctl_valid;
    alu_op_e   alu_op;
    op1_sel_e  op1_sel;
    op2_sel_e  op2_sel;
    pc_sel_e   pc_sel;
    logic      rf_we;
    logic      mem_en;
    logic      mem_wen;
    wb_sel_e   wb_sel;
    mem_size_e mem_size;
    logic      is_ebreak;

    exp_t exp_q [$];     // Words in flight, oldest first
    exp_t exp_now;       // Word being compared
    int   errors  = 0;
    int   checked = 0;

    ctrl_unit i_dut (.*);

    always #(CLK_HALF) clk = ~clk;

    // ALU code from funct3 and the funct7 alternate bit
    function automatic alu_op_e alu_code(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic ctl_word_t alu_row(input alu_op_e op, input op2_sel_e op2);
        ctl_word_t w;
        w         = '0;
        w.alu_op  = op;
        w.op2_sel = op2;
        w.rf_we   = 1'b1;
        w.wb_sel  = WB_ALU;
        return w;
    endfunction

    // Expected output for one strobe
    function automatic exp_t model_word(input inst_t ins, input logic eq, lt, ltu);
        exp_t       e;
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       alt;
        logic       taken;
        opc   = ins[6:0];
        f3    = ins[14:12];
        f7    = ins[31:25];
        alt   = (f7 == FUNCT7_ALT);
        taken = 1'b0;
        e     = '0;  // No row hit means all zero
        case (opc)
            OPC_OP: begin
                if (f7 == 7'h00 || (alt && (f3 == 3'b000 || f3 == 3'b101)))
                    e.word = alu_row(alu_code(f3, alt), OP2_RS2);
            end
            OPC_OP_IMM: begin
                // funct7 only counts for the right shifts
                if (f3 != 3'b101 || f7 == 7'h00 || alt)
                    e.word = alu_row(alu_code(f3, f3 == 3'b101 && alt), OP2_IMM);
            end
            OPC_LOAD: begin
                if (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) begin
                    e.word         = alu_row(ALU_ADD, OP2_IMM);
                    e.word.mem_en  = 1'b1;
                    e.word.wb_sel  = WB_MEM;
                    e.size         = f3;
                end
            end
            OPC_STORE: begin
                if (f3 inside {3'd0, 3'd1, 3'd2}) begin
                    e.word         = alu_row(ALU_ADD, OP2_SIMM);
                    e.word.rf_we   = 1'b0;
                    e.word.mem_en  = 1'b1;
                    e.word.mem_wen = 1'b1;
                    e.word.wb_sel  = WB_NONE;
                    e.size         = f3;
                end
            end
            OPC_BRANCH: begin
                case (f3)
                    3'b000:  taken = eq;
                    3'b001:  taken = !eq;
                    3'b100:  taken = lt;
                    3'b101:  taken = !lt;
                    3'b110:  taken = ltu;
                    3'b111:  taken = !ltu;
                    default: taken = 1'b0;
                endcase
                e.word.pc_sel = taken ? PC_BRANCH : PC_PLUS4;  // Rest of the row is zero
            end
            OPC_JAL: begin
                e.word.pc_sel = PC_JAL;
                e.word.rf_we  = 1'b1;
                e.word.wb_sel = WB_PC4;
            end
            OPC_JALR: begin
                if (f3 == 3'b000) begin
                    e.word.op2_sel = OP2_IMM;
                    e.word.pc_sel  = PC_JALR;
                    e.word.rf_we   = 1'b1;
                    e.word.wb_sel  = WB_PC4;
                end
            end
            OPC_AUIPC: begin
                e.word         = alu_row(ALU_ADD, OP2_IMM);
                e.word.op1_sel = OP1_PC;
            end
            default: ;
        endcase
        e.brk = (ins == EBREAK_INST);
        return e;
    endfunction

    // Random register and immediate bits around fixed fields
    function automatic inst_t make_inst(input logic [6:0] opc, f7, input logic [2:0] f3);
        logic [31:0] r;
        r = $urandom();
        return {f7, r[9:0], f3, r[14:10], opc};
    endfunction

    function automatic logic is_decoded_opcode(input logic [6:0] opc);
        return opc inside {OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_STORE,
                           OPC_BRANCH, OPC_JAL, OPC_JALR, OPC_AUIPC};
    endfunction

    task automatic check_field(input string name, input logic [31:0] exp, act);
        assert (exp === act) else begin
            errors++;
            $display("Fail %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic issue_inst(input inst_t ins, input logic eq, lt, ltu);
        @(posedge clk);
        #1;
        inst_valid = 1'b1;
        inst       = ins;
        br_eq      = eq;
        br_lt      = lt;
        br_ltu     = ltu;
        exp_q.push_back(model_word(ins, eq, lt, ltu));
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            inst_valid = 1'b0;
        end
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        if (rst_n && ctl_valid) begin
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("Control word appeared with no instruction outstanding");
            end
            if (exp_q.size() != 0) begin
                exp_now = exp_q.pop_front();
                checked++;
                check_field("alu_op", exp_now.word.alu_op, alu_op);
                check_field("op1_sel", exp_now.word.op1_sel, op1_sel);
                check_field("op2_sel", exp_now.word.op2_sel, op2_sel);
                check_field("pc_sel", exp_now.word.pc_sel, pc_sel);
                check_field("rf_we", exp_now.word.rf_we, rf_we);
                check_field("mem_en", exp_now.word.mem_en, mem_en);
                check_field("mem_wen", exp_now.word.mem_wen, mem_wen);
                check_field("wb_sel", exp_now.word.wb_sel, wb_sel);
                check_field("mem_size", exp_now.size, mem_size);
                check_field("is_ebreak", exp_now.brk, is_ebreak);
            end
        end
    end

    // All 36 table rows, back to back
    task automatic run_table_tests();
        logic [2:0]  imm_f3 [6] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};  // Non-shift OP-IMM
        logic [2:0]  load_f3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        logic [2:0]  br_f3 [6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        logic [31:0] r;
        for (int f3 = 0; f3 < 8; f3++) issue_inst(make_inst(OPC_OP, 7'h00, f3), 0, 0, 0);
        issue_inst(make_inst(OPC_OP, FUNCT7_ALT, 3'b000), 0, 0, 0);  // SUB
        issue_inst(make_inst(OPC_OP, FUNCT7_ALT, 3'b101), 0, 0, 0);  // SRA
        for (int i = 0; i < 6; i++) begin
            r = $urandom();
            issue_inst(make_inst(OPC_OP_IMM, r[6:0], imm_f3[i]), 0, 0, 0);
        end
        issue_inst(make_inst(OPC_OP_IMM, 7'h00, 3'b001), 0, 0, 0);
        issue_inst(make_inst(OPC_OP_IMM, 7'h00, 3'b101), 0, 0, 0);
        issue_inst(make_inst(OPC_OP_IMM, FUNCT7_ALT, 3'b101), 0, 0, 0);
        for (int i = 0; i < 5; i++) begin
            r = $urandom();
            issue_inst(make_inst(OPC_LOAD, r[6:0], load_f3[i]), 0, 0, 0);
        end
        for (int f3 = 0; f3 < 3; f3++) begin
            r = $urandom();
            issue_inst(make_inst(OPC_STORE, r[6:0], f3), 0, 0, 0);
        end
        for (int i = 0; i < 6; i++) begin
            r = $urandom();
            issue_inst(make_inst(OPC_BRANCH, r[6:0], br_f3[i]), r[7], r[8], r[9]);
        end
        r = $urandom();
        issue_inst({r[31:7], OPC_JAL}, 0, 0, 0);
        issue_inst(make_inst(OPC_JALR, r[6:0], 3'b000), 0, 0, 0);
        issue_inst({r[24:0], OPC_AUIPC}, 0, 0, 0);
        idle_cycles(1);
    endtask

    task automatic run_branch_tests();
        logic [2:0] br_f3 [6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        for (int i = 0; i < 6; i++) begin
            for (int k = 0; k < 8; k++) begin
                issue_inst(make_inst(OPC_BRANCH, 7'h00, br_f3[i]), k[0], k[1], k[2]);
            end
        end
        idle_cycles(1);
    endtask

    task automatic run_unmatched_tests();
        logic [31:0] r;
        logic [6:0]  opc;
        r = $urandom();
        issue_inst({r[31:7], 7'b0110111}, 0, 0, 0);               // LUI
        issue_inst(make_inst(OPC_OP, 7'h01, r[2:0]), 0, 0, 0);   // Multiply extension
        issue_inst(make_inst(OPC_JALR, 7'h00, 3'b001), 0, 0, 0);
        repeat (8) begin
            opc = 7'($urandom());
            while (is_decoded_opcode(opc)) opc = 7'($urandom());
            r = $urandom();
            issue_inst({r[31:7], opc}, r[0], r[1], r[2]);
        end
        issue_inst(EBREAK_INST, 0, 0, 0);
        issue_inst(32'h0000_0073, 0, 0, 0);  // ECALL
        idle_cycles(1);
    endtask

    // Mixed opcodes with gaps of zero to two idle cycles
    task automatic run_strobe_tests();
        logic [31:0] r;
        logic [6:0]  opc;
        for (int i = 0; i < 24; i++) begin
            r = $urandom();
            case (r[2:0])
                3'd0:    opc = OPC_OP;
                3'd1:    opc = OPC_OP_IMM;
                3'd2:    opc = OPC_LOAD;
                3'd3:    opc = OPC_STORE;
                3'd4:    opc = OPC_BRANCH;
                3'd5:    opc = OPC_JAL;
                3'd6:    opc = OPC_JALR;
                default: opc = OPC_AUIPC;
            endcase
            issue_inst({r[31:7], opc}, r[3], r[4], r[5]);
            idle_cycles(i % 3);
        end
        idle_cycles(1);
    endtask

    initial begin
        #(WATCHDOG);
        $display("Timeout after %0d time units with %0d words outstanding",
                 WATCHDOG, exp_q.size());
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        int total;
        void'($urandom(31));
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        br_eq      = 1'b0;
        br_lt      = 1'b0;
        br_ltu     = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        run_table_tests();
        run_branch_tests();
        run_unmatched_tests();
        run_strobe_tests();
        wait (exp_q.size() == 0);   // Last word compared
        idle_cycles(2);
        total = errors + i_dut.i_props.fail_count;
        $display("Checked %0d words, %0d field errors, %0d property errors",
                 checked, errors, i_dut.i_props.fail_count);
        if (total == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/rv_ctrl_pkg.sv
verilog/key_mux.sv
verilog/inst_decoder.sv
verilog/branch_resolver.sv
verilog/ctrl_unit.sv
verification/ctrl_unit_props.sv
verification/ctrl_unit_tb.sv

// ==== Bender.yml ====
package:
  name: rv_ctrl_unit

sources:
  - files:
      - verilog/rv_ctrl_pkg.sv
      - verilog/key_mux.sv
      - verilog/inst_decoder.sv
      - verilog/branch_resolver.sv
      - verilog/ctrl_unit.sv
  - target: test
    files:
      - verification/ctrl_unit_props.sv
      - verification/ctrl_unit_tb.sv
